// ==== logic/dbg_mem_pkg.sv ====
// ----------------------------------------
// debug memory package: address map, sizes,
// width types, fsm and error enums, and the
// jal encoder for the WHERETO jump words
// ----------------------------------------
`default_nettype none

package dbg_mem_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int unsigned NrHarts     = 4;
  localparam int unsigned HartSelLen  = 2;
  localparam int unsigned DataCount   = 2;
  localparam int unsigned ProgBufSize = 8;
  localparam int unsigned DbgAddrBits = 12;

  // width types
  typedef logic [NrHarts-1:0]        hart_vec_t;
  typedef logic [HartSelLen-1:0]     hart_idx_t;
  typedef logic [DbgAddrBits-1:0]    dbg_addr_t;
  typedef logic [31:0]               bus_word_t;
  typedef logic [3:0]                bus_be_t;
  typedef logic [DataCount*32-1:0]   data_regs_t;
  typedef logic [ProgBufSize*32-1:0] progbuf_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  // hart status writes
  localparam dbg_addr_t HaltedAddr      = 12'h100;
  localparam dbg_addr_t GoingAddr       = 12'h104;
  localparam dbg_addr_t ResumingAddr    = 12'h108;
  localparam dbg_addr_t ExceptionAddr   = 12'h10C;
  // jump word, program buffer and data registers
  localparam dbg_addr_t WhereToAddr     = 12'h300;
  localparam dbg_addr_t ProgBufBaseAddr = 12'h360;
  localparam dbg_addr_t DataBaseAddr    = 12'h380;
  // flag area polled by the harts, one byte per hart
  localparam dbg_addr_t FlagsBaseAddr   = 12'h400;
  localparam dbg_addr_t FlagsEndAddr    = 12'h7FF;
  // resume entry of the park loop
  localparam dbg_addr_t ResumeAddr      = 12'h804;

  // jal x0, imm: J-type immediate scattered as imm[20|10:1|11|19:12]
  function automatic bus_word_t jal_x0(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

  // relative jumps out of WHERETO
  localparam bus_word_t WhereToResumeInsn =
      jal_x0(21'(ResumeAddr) - 21'(WhereToAddr));
  localparam bus_word_t WhereToProgBufInsn =
      jal_x0(21'(ProgBufBaseAddr) - 21'(WhereToAddr));

  // command fsm
  typedef enum logic [1:0] {
    Idle,
    Go,
    Resume,
    CmdExecuting
  } state_e;

  // abstractcs.cmderr encodings
  typedef enum logic [2:0] {
    CmdErrNone       = 3'd0,
    CmdErrException  = 3'd3,
    CmdErrHaltResume = 3'd4
  } cmderr_e;

endpackage

`default_nettype wire

// ==== logic/dbg_cmd_fsm.sv ====
// ----------------------------------------
// command and resume fsm with busy output
// and command error reporting
// ----------------------------------------
`default_nettype none

module dbg_cmd_fsm (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire dbg_mem_pkg::hart_idx_t hartsel_i,
  input  wire logic                 cmd_valid_i,
  input  wire dbg_mem_pkg::hart_vec_t haltreq_i,
  input  wire dbg_mem_pkg::hart_vec_t resumereq_i,
  input  wire dbg_mem_pkg::hart_vec_t halted_i,
  input  wire dbg_mem_pkg::hart_vec_t resuming_i,
  input  wire logic                 halted_set_i,
  input  wire dbg_mem_pkg::hart_idx_t wdata_hart_i,
  input  wire logic                 going_i,
  input  wire logic                 exception_i,
  output logic                      go_o,
  output logic                      resume_o,
  output logic                      cmdbusy_o,
  output logic                      cmderror_valid_o,
  output dbg_mem_pkg::cmderr_e      cmderror_o
);

  dbg_mem_pkg::state_e state_d, state_q;

  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmdbusy_o        = 1'b1;
    cmderror_valid_o = 1'b0;
    cmderror_o       = dbg_mem_pkg::CmdErrNone;

    case (state_q)
      dbg_mem_pkg::Idle: begin
        cmdbusy_o = 1'b0;
        // commands only go to a halted hart
        if (cmd_valid_i && halted_i[hartsel_i]) begin
          state_d = dbg_mem_pkg::Go;
        end else if (cmd_valid_i) begin
          cmderror_valid_o = 1'b1;
          cmderror_o       = dbg_mem_pkg::CmdErrHaltResume;
        end
        // resume ignored while a halt is pending or the last ack is not cleared
        if (resumereq_i[hartsel_i] && !resuming_i[hartsel_i] &&
            !haltreq_i[hartsel_i] && halted_i[hartsel_i]) begin
          state_d = dbg_mem_pkg::Resume;
        end
      end
      dbg_mem_pkg::Go: begin
        // hart polls the go flag, then reports going
        go_o = 1'b1;
        if (going_i) begin
          state_d = dbg_mem_pkg::CmdExecuting;
        end
      end
      dbg_mem_pkg::Resume: begin
        resume_o = 1'b1;
        // wait for the ack bit to show up
        if (resuming_i[hartsel_i]) begin
          state_d = dbg_mem_pkg::Idle;
        end
      end
      dbg_mem_pkg::CmdExecuting: begin
        // program done once the selected hart parks again
        if (halted_set_i && (wdata_hart_i == hartsel_i)) begin
          state_d = dbg_mem_pkg::Idle;
        end
      end
      default: state_d = dbg_mem_pkg::Idle;
    endcase

    // exception wins over the halt error
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_mem_pkg::CmdErrException;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dbg_mem_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dbg_hart_status.sv ====
// ----------------------------------------
// per-hart halted and resuming flags
// ----------------------------------------
`default_nettype none

module dbg_hart_status (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire dbg_mem_pkg::hart_idx_t hartsel_i,
  input  wire dbg_mem_pkg::hart_idx_t wdata_hart_i,
  input  wire logic                   halted_set_i,
  input  wire logic                   resuming_set_i,
  input  wire logic                   clear_resumeack_i,
  output dbg_mem_pkg::hart_vec_t      halted_o,
  output dbg_mem_pkg::hart_vec_t      resuming_o
);

  dbg_mem_pkg::hart_vec_t halted_d, halted_q;
  dbg_mem_pkg::hart_vec_t resuming_d, resuming_q;

  always_comb begin
    halted_d   = halted_q;
    resuming_d = resuming_q;

    // debugger acknowledges the resume of the selected hart
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end

    // hart entered the park loop
    if (halted_set_i) begin
      halted_d[wdata_hart_i] = 1'b1;
    end

    // hart left the park loop, ack stays until cleared
    if (resuming_set_i) begin
      halted_d[wdata_hart_i]   = 1'b0;
      resuming_d[wdata_hart_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

endmodule

`default_nettype wire

// ==== logic/dbg_mem_write.sv ====
// ----------------------------------------
// hart write decode: status pulses and
// byte-enabled data register merge
// ----------------------------------------
`default_nettype none

module dbg_mem_write (
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire dbg_mem_pkg::dbg_addr_t  addr_i,
  input  wire dbg_mem_pkg::bus_word_t  wdata_i,
  input  wire dbg_mem_pkg::bus_be_t    be_i,
  input  wire dbg_mem_pkg::data_regs_t data_i,
  output dbg_mem_pkg::data_regs_t      data_o,
  output logic                         data_valid_o,
  output logic                         halted_set_o,
  output logic                         resuming_set_o,
  output logic                         going_o,
  output logic                         exception_o,
  output dbg_mem_pkg::hart_idx_t       wdata_hart_o
);

  logic wr;
  logic data_hit;

  assign wr = req_i && we_i;

  // data registers sit right above the program buffer
  assign data_hit = (addr_i >= dbg_mem_pkg::DataBaseAddr) &&
                    (addr_i < dbg_mem_pkg::DataBaseAddr + 4 * dbg_mem_pkg::DataCount);

  // hart writes its own index to the status addresses
  assign wdata_hart_o = wdata_i[dbg_mem_pkg::HartSelLen-1:0];

  // ----------------------------------------
  // status pulses
  // ----------------------------------------
  assign halted_set_o   = wr && (addr_i == dbg_mem_pkg::HaltedAddr);
  assign going_o        = wr && (addr_i == dbg_mem_pkg::GoingAddr);
  assign resuming_set_o = wr && (addr_i == dbg_mem_pkg::ResumingAddr);
  assign exception_o    = wr && (addr_i == dbg_mem_pkg::ExceptionAddr);

  // ----------------------------------------
  // data register merge
  // ----------------------------------------
  always_comb begin
    data_o       = data_i;
    data_valid_o = 1'b0;
    if (wr && data_hit) begin
      data_valid_o = 1'b1;
      // addr bit 2 picks the 32-bit register, be picks the bytes
      for (int i = 0; i < $bits(dbg_mem_pkg::bus_be_t); i++) begin
        if (be_i[i]) begin
          data_o[32 * addr_i[2] + 8 * i +: 8] = wdata_i[8 * i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/dbg_mem_read.sv ====
// ----------------------------------------
// read mux and registered read data for
// WHERETO, program buffer, data and flags
// ----------------------------------------
`default_nettype none

module dbg_mem_read (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire dbg_mem_pkg::dbg_addr_t  addr_i,
  input  wire dbg_mem_pkg::hart_idx_t  hartsel_i,
  input  wire dbg_mem_pkg::hart_vec_t  resumereq_i,
  input  wire dbg_mem_pkg::data_regs_t data_i,
  input  wire dbg_mem_pkg::progbuf_t   progbuf_i,
  input  wire logic                    go_i,
  input  wire logic                    resume_i,
  input  wire logic                    cmdbusy_i,
  output dbg_mem_pkg::bus_word_t       rdata_o
);

  dbg_mem_pkg::bus_word_t rdata_d, rdata_q;
  dbg_mem_pkg::bus_word_t flag_word;

  // word offsets from each region base
  logic [dbg_mem_pkg::DbgAddrBits-3:0] pb_word;
  logic [dbg_mem_pkg::DbgAddrBits-3:0] data_word;
  logic [dbg_mem_pkg::DbgAddrBits-3:0] flag_word_idx;

  logic pb_hit;
  logic data_hit;
  logic flag_hit;

  assign pb_word       = addr_i[dbg_mem_pkg::DbgAddrBits-1:2] -
                         dbg_mem_pkg::ProgBufBaseAddr[dbg_mem_pkg::DbgAddrBits-1:2];
  assign data_word     = addr_i[dbg_mem_pkg::DbgAddrBits-1:2] -
                         dbg_mem_pkg::DataBaseAddr[dbg_mem_pkg::DbgAddrBits-1:2];
  assign flag_word_idx = addr_i[dbg_mem_pkg::DbgAddrBits-1:2] -
                         dbg_mem_pkg::FlagsBaseAddr[dbg_mem_pkg::DbgAddrBits-1:2];

  assign pb_hit   = (addr_i >= dbg_mem_pkg::ProgBufBaseAddr) &&
                    (addr_i < dbg_mem_pkg::ProgBufBaseAddr + 4 * dbg_mem_pkg::ProgBufSize);
  assign data_hit = (addr_i >= dbg_mem_pkg::DataBaseAddr) &&
                    (addr_i < dbg_mem_pkg::DataBaseAddr + 4 * dbg_mem_pkg::DataCount);
  assign flag_hit = (addr_i >= dbg_mem_pkg::FlagsBaseAddr) &&
                    (addr_i <= dbg_mem_pkg::FlagsEndAddr);

  // one flag byte per hart, four harts per word
  always_comb begin
    flag_word = '0;
    if (flag_word_idx == (dbg_mem_pkg::DbgAddrBits - 2)'(hartsel_i >> 2)) begin
      flag_word[8 * hartsel_i[1:0] +: 8] = {6'b0, resume_i, go_i};
    end
  end

  // ----------------------------------------
  // read select
  // ----------------------------------------
  always_comb begin
    // unmapped reads keep the last word
    rdata_d = rdata_q;
    if (req_i && !we_i) begin
      if (addr_i == dbg_mem_pkg::WhereToAddr) begin
        // busy sends the hart into the program buffer
        if (cmdbusy_i) begin
          rdata_d = dbg_mem_pkg::WhereToProgBufInsn;
        end else if (resumereq_i[hartsel_i]) begin
          rdata_d = dbg_mem_pkg::WhereToResumeInsn;
        end
      end else if (pb_hit) begin
        rdata_d = progbuf_i[32 * pb_word +: 32];
      end else if (data_hit) begin
        rdata_d = data_i[32 * data_word +: 32];
      end else if (flag_hit) begin
        rdata_d = flag_word;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== logic/dbg_mem_top.sv ====
// ----------------------------------------
// debug memory top level: write decode, hart
// status, command fsm and read mux
// ----------------------------------------
`default_nettype none

module dbg_mem_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  output dbg_mem_pkg::hart_vec_t       debug_req_o,
  input  wire logic [19:0]             hartsel_i,
  // from dmcontrol
  input  wire dbg_mem_pkg::hart_vec_t  haltreq_i,
  input  wire dbg_mem_pkg::hart_vec_t  resumereq_i,
  input  wire logic                    clear_resumeack_i,
  // hart state
  output dbg_mem_pkg::hart_vec_t       halted_o,
  output dbg_mem_pkg::hart_vec_t       resuming_o,
  input  wire dbg_mem_pkg::progbuf_t   progbuf_i,
  input  wire dbg_mem_pkg::data_regs_t data_i,
  output dbg_mem_pkg::data_regs_t      data_o,
  output logic                         data_valid_o,
  // abstract command handshake
  input  wire logic                    cmd_valid_i,
  output logic                         cmderror_valid_o,
  output dbg_mem_pkg::cmderr_e         cmderror_o,
  output logic                         cmdbusy_o,
  // sram port from the harts
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire dbg_mem_pkg::bus_word_t  addr_i,
  input  wire dbg_mem_pkg::bus_word_t  wdata_i,
  input  wire dbg_mem_pkg::bus_be_t    be_i,
  output dbg_mem_pkg::bus_word_t       rdata_o
);

  dbg_mem_pkg::hart_idx_t hartsel;
  dbg_mem_pkg::dbg_addr_t addr;
  dbg_mem_pkg::hart_idx_t wdata_hart;
  logic halted_set, resuming_set, going, exception;
  logic go, resume;

  // only the low bits decode
  assign hartsel     = hartsel_i[dbg_mem_pkg::HartSelLen-1:0];
  assign addr        = addr_i[dbg_mem_pkg::DbgAddrBits-1:0];
  assign debug_req_o = haltreq_i;

  dbg_mem_write dbg_mem_write_i (
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .data_i         (data_i),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o),
    .halted_set_o   (halted_set),
    .resuming_set_o (resuming_set),
    .going_o        (going),
    .exception_o    (exception),
    .wdata_hart_o   (wdata_hart)
  );

  dbg_hart_status dbg_hart_status_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .hartsel_i         (hartsel),
    .wdata_hart_i      (wdata_hart),
    .halted_set_i      (halted_set),
    .resuming_set_i    (resuming_set),
    .clear_resumeack_i (clear_resumeack_i),
    .halted_o          (halted_o),
    .resuming_o        (resuming_o)
  );

  dbg_cmd_fsm dbg_cmd_fsm_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .hartsel_i        (hartsel),
    .cmd_valid_i      (cmd_valid_i),
    .haltreq_i        (haltreq_i),
    .resumereq_i      (resumereq_i),
    .halted_i         (halted_o),
    .resuming_i       (resuming_o),
    .halted_set_i     (halted_set),
    .wdata_hart_i     (wdata_hart),
    .going_i          (going),
    .exception_i      (exception),
    .go_o             (go),
    .resume_o         (resume),
    .cmdbusy_o        (cmdbusy_o),
    .cmderror_valid_o (cmderror_valid_o),
    .cmderror_o       (cmderror_o)
  );

  dbg_mem_read dbg_mem_read_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr),
    .hartsel_i   (hartsel),
    .resumereq_i (resumereq_i),
    .data_i      (data_i),
    .progbuf_i   (progbuf_i),
    .go_i        (go),
    .resume_i    (resume),
    .cmdbusy_i   (cmdbusy_o),
    .rdata_o     (rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_dbg_mem.sv ====
// ----------------------------------------
// table-driven testbench for the debug memory
// with clock, reset, step table, watchdog and
// the check task
// ----------------------------------------
`default_nettype none

module tb_dbg_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 20;
  localparam int max_steps  = 64;
  localparam int tb_hart    = 1;
  // which output a step compares
  localparam int sig_none       = 0;
  localparam int sig_busy       = 1;
  localparam int sig_err_valid  = 2;
  localparam int sig_err        = 3;
  localparam int sig_halted     = 4;
  localparam int sig_resuming   = 5;
  localparam int sig_rdata      = 6;
  localparam int sig_data_valid = 7;
  localparam int sig_data_o     = 8;
  localparam int sig_debug_req  = 9;

  logic clk_i, rst_ni, clear_resumeack_i, cmd_valid_i, req_i, we_i;
  logic [19:0] hartsel_i;
  dbg_mem_pkg::hart_vec_t haltreq_i, resumereq_i, debug_req_o, halted_o, resuming_o;
  dbg_mem_pkg::progbuf_t progbuf_i;
  dbg_mem_pkg::data_regs_t data_i, data_o;
  dbg_mem_pkg::bus_word_t addr_i, wdata_i, rdata_o;
  dbg_mem_pkg::bus_be_t be_i;
  dbg_mem_pkg::cmderr_e cmderror_o;
  logic data_valid_o, cmderror_valid_o, cmdbusy_o;

  // step table with one row per clock cycle
  logic        st_cmd [max_steps];
  logic        st_clr [max_steps];
  logic [3:0]  st_halt[max_steps];
  logic [3:0]  st_res [max_steps];
  logic        st_req [max_steps];
  logic        st_we  [max_steps];
  logic [31:0] st_addr[max_steps];
  logic [31:0] st_wd  [max_steps];
  logic [3:0]  st_be  [max_steps];
  int          st_sig [max_steps];
  logic [63:0] st_exp [max_steps];
  int n_steps = 0;
  int n_pass  = 0;
  int n_fail  = 0;
  // halt and resume request levels held by the rows pushed next
  logic [3:0] pend_haltreq = '0;
  logic [3:0] pend_resreq  = '0;

  always #(clk_period / 2) clk_i = ~clk_i;

  dbg_mem_top dbg_mem_top_i (.*);

  task automatic push_step(input logic cmd, input logic clr, input logic req, input logic we,
                           input logic [31:0] addr, input logic [31:0] wd,
                           input logic [3:0] be, input int sig, input logic [63:0] exp);
    st_cmd[n_steps] = cmd;
    st_clr[n_steps] = clr;
    st_halt[n_steps] = pend_haltreq;
    st_res[n_steps] = pend_resreq;
    st_req[n_steps] = req;
    st_we[n_steps] = we;
    st_addr[n_steps] = addr;
    st_wd[n_steps] = wd;
    st_be[n_steps] = be;
    st_sig[n_steps] = sig;
    st_exp[n_steps] = exp;
    n_steps++;
  endtask

  task automatic idle_row(input int sig, input logic [63:0] exp);
    push_step(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, sig, exp);
  endtask

  task automatic cmd_row(input int sig, input logic [63:0] exp);
    push_step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0, sig, exp);
  endtask

  task automatic ack_row(input int sig, input logic [63:0] exp);
    push_step(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0, sig, exp);
  endtask

  task automatic bus_read(input logic [31:0] addr, input int sig, input logic [63:0] exp);
    push_step(1'b0, 1'b0, 1'b1, 1'b0, addr, '0, '0, sig, exp);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wd, input logic [3:0] be,
                           input int sig, input logic [63:0] exp);
    push_step(1'b0, 1'b0, 1'b1, 1'b1, addr, wd, be, sig, exp);
  endtask

  // enabled bytes come from the bus word and the rest stays
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8 * b +: 8] = wd[8 * b +: 8];
      end
    end
    return res;
  endfunction

  // flag byte of the test hart with go in bit 0 and resume in bit 1
  function automatic logic [63:0] flag_word(input logic go, input logic resume);
    return 64'(32'({resume, go}) << (8 * tb_hart));
  endfunction

  function automatic string sig_name(input int sig);
    case (sig)
      sig_busy:       return "cmdbusy_o";
      sig_err_valid:  return "cmderror_valid_o";
      sig_err:        return "cmderror_o";
      sig_halted:     return "halted_o";
      sig_resuming:   return "resuming_o";
      sig_rdata:      return "rdata_o";
      sig_data_valid: return "data_valid_o";
      sig_debug_req:  return "debug_req_o";
      default:        return "data_o";
    endcase
  endfunction

  function automatic logic [63:0] sample_sig(input int sig);
    case (sig)
      sig_busy:       return 64'(cmdbusy_o);
      sig_err_valid:  return 64'(cmderror_valid_o);
      sig_err:        return 64'(cmderror_o);
      sig_halted:     return 64'(halted_o);
      sig_resuming:   return 64'(resuming_o);
      sig_rdata:      return 64'(rdata_o);
      sig_data_valid: return 64'(data_valid_o);
      sig_debug_req:  return 64'(debug_req_o);
      default:        return data_o;
    endcase
  endfunction

  task automatic check_value(input int step, input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR step %0d %s: got 0x%h expected 0x%h", step, name, got, exp);
      n_fail++;
    end else begin
      $display("step %0d %s ok (0x%h)", step, name, got);
      n_pass++;
    end
  endtask

  // ----------------------------------------
  // step table
  // ----------------------------------------
  task automatic build_table();
    logic [31:0] wd0, wd1;
    logic [3:0] be0, be1;
    wd0 = $urandom;
    wd1 = $urandom;
    be0 = 4'($urandom);
    be1 = 4'($urandom);
    // reset values
    idle_row(sig_busy, 0);
    idle_row(sig_halted, 0);
    idle_row(sig_resuming, 0);
    idle_row(sig_rdata, 0);
    idle_row(sig_err_valid, 0);
    idle_row(sig_data_valid, 0);
    // command to a running hart
    cmd_row(sig_err_valid, 1);
    cmd_row(sig_err, 64'(dbg_mem_pkg::CmdErrHaltResume));
    idle_row(sig_busy, 0);
    // hart parks and a command then runs through go and executing
    bus_write(32'(dbg_mem_pkg::HaltedAddr), tb_hart, 4'hf, sig_busy, 0);
    idle_row(sig_halted, 64'(4'b1 << tb_hart));
    cmd_row(sig_err_valid, 0);
    idle_row(sig_busy, 1);
    bus_read(32'(dbg_mem_pkg::FlagsBaseAddr), sig_none, 0);
    bus_read(32'(dbg_mem_pkg::WhereToAddr), sig_rdata, flag_word(1'b1, 1'b0));
    idle_row(sig_rdata, 64'(dbg_mem_pkg::WhereToProgBufInsn));
    // the next flag word holds no hart of this design
    bus_read(32'(dbg_mem_pkg::FlagsBaseAddr) + 4, sig_none, 0);
    idle_row(sig_rdata, 0);
    bus_write(32'(dbg_mem_pkg::GoingAddr), tb_hart, 4'hf, sig_busy, 1);
    idle_row(sig_busy, 1);
    bus_write(32'(dbg_mem_pkg::HaltedAddr), tb_hart, 4'hf, sig_busy, 1);
    idle_row(sig_busy, 0);
    // a pending halt request on the hart holds off the resume
    pend_haltreq = 4'b1011;
    pend_resreq = 4'(4'b1 << tb_hart);
    idle_row(sig_debug_req, 64'(4'b1011));
    pend_haltreq = '0;
    // resume of the halted hart
    bus_read(32'(dbg_mem_pkg::WhereToAddr), sig_busy, 0);
    bus_read(32'(dbg_mem_pkg::FlagsBaseAddr), sig_rdata,
             64'(dbg_mem_pkg::WhereToResumeInsn));
    idle_row(sig_rdata, flag_word(1'b0, 1'b1));
    bus_write(32'(dbg_mem_pkg::ResumingAddr), tb_hart, 4'hf, sig_none, 0);
    idle_row(sig_halted, 0);
    idle_row(sig_resuming, 64'(4'b1 << tb_hart));
    pend_resreq = '0;
    ack_row(sig_busy, 0);
    idle_row(sig_resuming, 0);
    // exception reported by the hart
    bus_write(32'(dbg_mem_pkg::ExceptionAddr), 0, 4'hf, sig_err_valid, 1);
    bus_write(32'(dbg_mem_pkg::ExceptionAddr), 0, 4'hf, sig_err,
              64'(dbg_mem_pkg::CmdErrException));
    // exception beats the halt error of a command to the running hart
    push_step(1'b1, 1'b0, 1'b1, 1'b1, 32'(dbg_mem_pkg::ExceptionAddr), 0, 4'hf, sig_err,
              64'(dbg_mem_pkg::CmdErrException));
    // data register merges
    bus_write(32'(dbg_mem_pkg::DataBaseAddr), wd0, be0, sig_data_o,
              {data_i[63:32], merge_bytes(data_i[31:0], wd0, be0)});
    bus_write(32'(dbg_mem_pkg::DataBaseAddr), wd0, be0, sig_data_valid, 1);
    bus_write(32'(dbg_mem_pkg::DataBaseAddr) + 4, wd1, be1, sig_data_o,
              {merge_bytes(data_i[63:32], wd1, be1), data_i[31:0]});
    // reads are pipelined and each row checks the word of the row before
    bus_read(32'(dbg_mem_pkg::DataBaseAddr), sig_data_valid, 0);
    bus_read(32'(dbg_mem_pkg::DataBaseAddr) + 4, sig_rdata, 64'(data_i[31:0]));
    idle_row(sig_rdata, 64'(data_i[63:32]));
    for (int k = 0; k < 8; k++) begin
      bus_read(32'(dbg_mem_pkg::ProgBufBaseAddr) + 4 * k, (k == 0) ? sig_none : sig_rdata,
               (k == 0) ? 64'd0 : 64'(progbuf_i[32 * (k - 1) +: 32]));
    end
    idle_row(sig_rdata, 64'(progbuf_i[255:224]));
  endtask

  // watchdog sized from the table length
  initial begin
    wait (n_steps > 0);
    #((n_steps * 20 + 10) * clk_period);
    $display("timeout: the step table did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h36fd));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    hartsel_i = 20'(tb_hart);
    {haltreq_i, resumereq_i, clear_resumeack_i, cmd_valid_i} = '0;
    {req_i, we_i, addr_i, wdata_i, be_i} = '0;
    data_i = {$urandom, $urandom};
    for (int k = 0; k < 8; k++) begin
      progbuf_i[32 * k +: 32] = $urandom;
    end
    build_table();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    // drive on the rising edge and compare in the middle of the cycle
    for (int i = 0; i < n_steps; i++) begin
      @(posedge clk_i);
      cmd_valid_i <= st_cmd[i];
      clear_resumeack_i <= st_clr[i];
      haltreq_i <= st_halt[i];
      resumereq_i <= st_res[i];
      req_i <= st_req[i];
      we_i <= st_we[i];
      addr_i <= st_addr[i];
      wdata_i <= st_wd[i];
      be_i <= st_be[i];
      @(negedge clk_i);
      if (st_sig[i] != sig_none) check_value(i, sig_name(st_sig[i]), sample_sig(st_sig[i]),
                                             st_exp[i]);
    end
    $display("tests run %0d, passed %0d, mismatches %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/dbg_mem_pkg.sv
logic/dbg_cmd_fsm.sv
logic/dbg_hart_status.sv
logic/dbg_mem_write.sv
logic/dbg_mem_read.sv
logic/dbg_mem_top.sv
tb/tb_dbg_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_dbg_mem -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dbg_mem > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
  exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi

exit 0
